// ==== files.f ====
verilog/dcache_pkg.sv
verilog/dcache_frames.sv
verilog/dcache_ctrl.sv
verilog/dcache.sv
dv/dcache_checker.sv
dv/tb_dcache.sv

// ==== run.sh ====
#!/bin/sh
# build and run the dcache testbench with Verilator
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal -f files.f \
    --top-module tb_dcache -Mdir obj_dir -o tb_dcache
if [ $? -ne 0 ]; then
    echo "verilator build failed"
    exit 1
fi

out=$(./obj_dir/tb_dcache)
status=$?
echo "$out"
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

echo "$out" | grep -q "^TEST PASSED$" || exit 1
exit 0

// ==== dv/tb_dcache.sv ====
`timescale 1ns/1ns

module tb_dcache;
    import dcache_pkg::*;

    localparam int HIT_WAIT   = 100;    // cycles
    localparam int FLUSH_WAIT = 2000;

    logic  CLK;
    logic  nRST;
    logic  dmemren;
    logic  dmemwen;
    logic  halt;
    word_t dmemaddr;
    word_t dmemstore;
    logic  dhit;
    logic  flushed;
    word_t dmemload;
    logic  dren;
    logic  dwen;
    word_t daddr;
    word_t dstore;
    word_t dload;
    logic  dwait;

    word_t mem [word_t];    // memory model, written words only
    int    mem_reads    = 0;
    int    mem_writes   = 0;
    int    wait_left    = -1;
    int    other_errors = 0;

    dcache #(.IDX_W(DEF_IDX_W)) UUT (
        .CLK(CLK), .nRST(nRST), .dmemren(dmemren), .dmemwen(dmemwen), .halt(halt),
        .dmemaddr(dmemaddr), .dmemstore(dmemstore), .dhit(dhit), .flushed(flushed),
        .dmemload(dmemload), .dren(dren), .dwen(dwen), .daddr(daddr), .dstore(dstore),
        .dload(dload), .dwait(dwait)
    );

    dcache_checker u_checker (
        .CLK(CLK), .nRST(nRST), .dmemren(dmemren), .dmemwen(dmemwen),
        .dmemaddr(dmemaddr), .dmemstore(dmemstore), .dmemload(dmemload), .dhit(dhit),
        .flushed(flushed), .dwen(dwen), .dwait(dwait), .daddr(daddr), .dstore(dstore)
    );

    initial begin
        CLK = 1'b0;
        forever #4 CLK = ~CLK;
    end

    function automatic word_t initial_word(word_t a);
        return (a * 32'h0101_0101) ^ 32'hc3a5_0f96;
    endfunction

    // memory answers after 0 to 3 wait cycles
    initial begin
        dwait = 1'b1;
        dload = '0;
        forever begin
            @(negedge CLK);
            if ((dren || dwen) && !dwait) begin    // access completes at the next edge
                if (dwen) begin
                    mem[daddr] = dstore;
                    mem_writes++;
                end else begin
                    mem_reads++;
                end
                wait_left = -1;
            end
            @(posedge CLK);
            #1;
            if (!(dren || dwen)) begin
                dwait     = 1'b1;
                wait_left = -1;
            end else begin
                if (wait_left < 0) wait_left = $urandom % 4;
                if (wait_left == 0) begin
                    dwait = 1'b0;
                    dload = mem.exists(daddr) ? mem[daddr] : initial_word(daddr);
                end else begin
                    dwait = 1'b1;
                    wait_left--;
                end
            end
        end
    end

    task automatic report_error(string msg);
        other_errors++;
        $display("%s", msg);
    endtask

    task automatic abort_run(string msg);
        $display("%s", msg);
        $display("read checks=%0d mismatches=%0d other errors=%0d",
                 u_checker.check_count, u_checker.mismatch_count, other_errors + 1);
        $display("TEST FAILED");
        $finish;
    endtask

    // one request, held until dhit
    task automatic access(bit is_write, word_t addr, word_t data);
        int n;
        dmemren   = !is_write;
        dmemwen   = is_write;
        dmemaddr  = addr;
        dmemstore = data;
        n = 0;
        @(negedge CLK);
        while (!dhit && n < HIT_WAIT) begin
            @(negedge CLK);
            n++;
        end
        if (!dhit) abort_run($sformatf("timeout: no dhit for address %h", addr));
        @(posedge CLK);
        #1;
        dmemren = 1'b0;
        dmemwen = 1'b0;
    endtask

    initial begin
        int    reads_before;
        int    writes_before;
        int    n;
        bit    wr;
        word_t a;
        word_t data;
        void'($urandom(32'h8931_1f06));
        nRST      = 1'b0;
        dmemren   = 1'b0;
        dmemwen   = 1'b0;
        halt      = 1'b0;
        dmemaddr  = '0;
        dmemstore = '0;
        repeat (4) @(posedge CLK);
        #1 nRST = 1'b1;

        u_checker.test_name = "cold_read";
        access(1'b0, 32'h100, '0);
        reads_before = mem_reads;
        access(1'b0, 32'h104, '0);
        if (mem_reads != reads_before) report_error("cold_read: other word of block missed");

        u_checker.test_name = "write_hit";
        access(1'b1, 32'h104, 32'hdead_beef);
        access(1'b0, 32'h104, '0);

        // set 2, three tags
        u_checker.test_name = "eviction";
        writes_before = mem_writes;
        access(1'b1, 32'h010, 32'h1111_0010);
        access(1'b1, 32'h050, 32'h2222_0050);
        access(1'b1, 32'h090, 32'h3333_0090);
        access(1'b0, 32'h010, '0);
        if (mem_writes == writes_before) report_error("eviction: dirty victim never written back");

        // set 5: A, B, A again, then C must replace B
        u_checker.test_name = "recency";
        access(1'b0, 32'h028, '0);
        access(1'b0, 32'h068, '0);
        access(1'b0, 32'h028, '0);
        access(1'b0, 32'h0a8, '0);
        reads_before = mem_reads;
        access(1'b0, 32'h028, '0);
        if (mem_reads != reads_before) report_error("recency: recently used block was evicted");

        u_checker.test_name = "random_mix";
        repeat (300) begin
            wr   = 1'($urandom % 2);
            a    = {23'd0, 7'($urandom % 128), 2'b00};
            data = $urandom;
            access(wr, a, data);
        end

        u_checker.test_name = "halt_flush";
        writes_before = mem_writes;
        halt = 1'b1;
        n = 0;
        @(negedge CLK);
        while (!flushed && n < FLUSH_WAIT) begin
            @(negedge CLK);
            n++;
        end
        if (!flushed) abort_run("timeout: flushed never rose after halt");
        repeat (4) @(negedge CLK);
        if (!flushed) report_error("halt_flush: flushed dropped before reset");
        if (mem_writes == writes_before) report_error("halt_flush: no dirty frame written back");

        $display("read checks=%0d mismatches=%0d other errors=%0d",
                 u_checker.check_count, u_checker.mismatch_count, other_errors);
        if (u_checker.mismatch_count == 0 && other_errors == 0) begin
            $display("TEST PASSED");
        end else begin
            $display("TEST FAILED");
        end
        $finish;
    end

endmodule

// ==== dv/dcache_checker.sv ====
`timescale 1ns/1ns

module dcache_checker (
    input  logic              CLK,
    input  logic              nRST,
    input  logic              dmemren,
    input  logic              dmemwen,
    input  dcache_pkg::word_t dmemaddr,
    input  dcache_pkg::word_t dmemstore,
    input  dcache_pkg::word_t dmemload,
    input  logic              dhit,
    input  logic              flushed,
    input  logic              dwen,
    input  logic              dwait,
    input  dcache_pkg::word_t daddr,
    input  dcache_pkg::word_t dstore
);
    import dcache_pkg::*;

    string test_name      = "none";   // set by the testbench per sequence
    int    check_count    = 0;
    int    mismatch_count = 0;
    logic  flush_checked  = 1'b0;
    word_t shadow   [word_t];         // last word the datapath stored
    word_t mem_seen [word_t];         // words the cache wrote to memory
    bit    used     [word_t];

    // memory contents before any write
    function automatic word_t initial_word(word_t a);
        return (a * 32'h0101_0101) ^ 32'hc3a5_0f96;
    endfunction

    function automatic word_t ref_read(word_t a);
        return shadow.exists(a) ? shadow[a] : initial_word(a);
    endfunction

    task automatic compare_word(word_t addr, word_t expected, word_t actual);
        check_count++;
        if (actual !== expected) begin
            mismatch_count++;
            $display("Mismatch test=%s addr=%h expected=%h actual=%h",
                     test_name, addr, expected, actual);
        end
    endtask

    // outputs are settled by the falling edge
    always @(negedge CLK) begin
        if (nRST) begin
            if (dhit && dmemren) begin
                compare_word(dmemaddr, ref_read(dmemaddr), dmemload);
                used[dmemaddr] = 1'b1;
            end
            if (dhit && dmemwen) begin
                shadow[dmemaddr] = dmemstore;
                used[dmemaddr]   = 1'b1;
            end
            if (dwen && !dwait) mem_seen[daddr] = dstore;   // accepted this cycle
            if (flushed && !flush_checked) begin
                flush_checked = 1'b1;
                // memory after the flush must hold every stored word
                foreach (used[a]) begin
                    compare_word(a, ref_read(a),
                                 mem_seen.exists(a) ? mem_seen[a] : initial_word(a));
                end
            end
        end
    end

endmodule

// ==== verilog/dcache.sv ====
`timescale 1ns/1ns

module dcache #(
    parameter int IDX_W = dcache_pkg::DEF_IDX_W
) (
    input  logic              CLK,
    input  logic              nRST,
    // datapath side
    input  logic              dmemren,
    input  logic              dmemwen,
    input  logic              halt,
    input  dcache_pkg::word_t dmemaddr,
    input  dcache_pkg::word_t dmemstore,
    output logic              dhit,
    output logic              flushed,
    output dcache_pkg::word_t dmemload,
    // memory side
    output logic              dren,
    output logic              dwen,
    output dcache_pkg::word_t daddr,
    output dcache_pkg::word_t dstore,
    input  dcache_pkg::word_t dload,
    input  logic              dwait
);
    import dcache_pkg::*;

    localparam int TAG_W = WORD_W - IDX_W - BLK_W - BYT_W;

    logic             lookup_en;
    logic             victim_dirty;
    logic [TAG_W-1:0] victim_tag;
    word_t            victim_word0;
    word_t            victim_word1;
    logic             fill_en;
    logic             fill_blk;
    logic             fill_last;
    logic [IDX_W:0]   scan_frame;
    logic             scan_valid_dirty;
    logic [TAG_W-1:0] scan_tag;
    word_t            scan_word0;
    word_t            scan_word1;

    // hit is only possible in idle, so it goes straight out as dhit
    dcache_frames #(.IDX_W(IDX_W)) u_frames (
        .CLK              (CLK),
        .nRST             (nRST),
        .lookup_en        (lookup_en),
        .dmemren          (dmemren),
        .dmemwen          (dmemwen),
        .dmemaddr         (dmemaddr),
        .dmemstore        (dmemstore),
        .hit              (dhit),
        .dmemload         (dmemload),
        .victim_dirty     (victim_dirty),
        .victim_tag       (victim_tag),
        .victim_word0     (victim_word0),
        .victim_word1     (victim_word1),
        .fill_en          (fill_en),
        .fill_blk         (fill_blk),
        .fill_last        (fill_last),
        .dload            (dload),
        .scan_frame       (scan_frame),
        .scan_valid_dirty (scan_valid_dirty),
        .scan_tag         (scan_tag),
        .scan_word0       (scan_word0),
        .scan_word1       (scan_word1)
    );

    dcache_ctrl #(.IDX_W(IDX_W)) u_ctrl (
        .CLK              (CLK),
        .nRST             (nRST),
        .dmemren          (dmemren),
        .dmemwen          (dmemwen),
        .halt             (halt),
        .dmemaddr         (dmemaddr),
        .hit              (dhit),
        .victim_dirty     (victim_dirty),
        .victim_tag       (victim_tag),
        .victim_word0     (victim_word0),
        .victim_word1     (victim_word1),
        .scan_valid_dirty (scan_valid_dirty),
        .scan_tag         (scan_tag),
        .scan_word0       (scan_word0),
        .scan_word1       (scan_word1),
        .dwait            (dwait),
        .lookup_en        (lookup_en),
        .fill_en          (fill_en),
        .fill_blk         (fill_blk),
        .fill_last        (fill_last),
        .scan_frame       (scan_frame),
        .flushed          (flushed),
        .dren             (dren),
        .dwen             (dwen),
        .daddr            (daddr),
        .dstore           (dstore)
    );

endmodule

// ==== verilog/dcache_ctrl.sv ====
`timescale 1ns/1ns

module dcache_ctrl #(
    parameter int IDX_W = dcache_pkg::DEF_IDX_W,
    localparam int TAG_W = dcache_pkg::WORD_W - IDX_W - dcache_pkg::BLK_W - dcache_pkg::BYT_W
) (
    input  logic              CLK,
    input  logic              nRST,
    input  logic              dmemren,
    input  logic              dmemwen,
    input  logic              halt,
    input  dcache_pkg::word_t dmemaddr,
    // from the frame store
    input  logic              hit,
    input  logic              victim_dirty,
    input  logic [TAG_W-1:0]  victim_tag,
    input  dcache_pkg::word_t victim_word0,
    input  dcache_pkg::word_t victim_word1,
    input  logic              scan_valid_dirty,
    input  logic [TAG_W-1:0]  scan_tag,
    input  dcache_pkg::word_t scan_word0,
    input  dcache_pkg::word_t scan_word1,
    input  logic              dwait,
    // to the frame store
    output logic              lookup_en,
    output logic              fill_en,
    output logic              fill_blk,
    output logic              fill_last,
    output logic [IDX_W:0]    scan_frame,
    output logic              flushed,
    // memory side
    output logic              dren,
    output logic              dwen,
    output dcache_pkg::word_t daddr,
    output dcache_pkg::word_t dstore
);
    import dcache_pkg::*;

    localparam logic [IDX_W:0] LAST_FRAME = '1;

    ctrl_state_t      state_q;
    ctrl_state_t      state_d;
    logic [IDX_W:0]   scan_q;
    logic [IDX_W:0]   scan_d;
    logic [TAG_W-1:0] req_tag;
    logic [IDX_W-1:0] req_idx;
    logic [IDX_W-1:0] scan_idx;

    // word address inside a block
    function automatic word_t blk_addr(logic [TAG_W-1:0] tag, logic [IDX_W-1:0] idx,
                                       logic blk);
        blk_addr = {tag, idx, BLK_W'(blk), {BYT_W{1'b0}}};
    endfunction

    assign req_tag  = dmemaddr[WORD_W-1 -: TAG_W];
    assign req_idx  = dmemaddr[BYT_W+BLK_W +: IDX_W];
    assign scan_idx = scan_q[IDX_W-1:0];

    assign lookup_en  = (state_q == ST_IDLE) && !halt;
    assign scan_frame = scan_q;
    assign flushed    = (state_q == ST_HALTED);

    always_ff @(posedge CLK, negedge nRST) begin
        if (!nRST) begin
            state_q <= ST_IDLE;
            scan_q  <= '0;
        end else begin
            state_q <= state_d;
            scan_q  <= scan_d;
        end
    end

    always_comb begin
        state_d = state_q;
        scan_d  = scan_q;
        case (state_q)
            ST_IDLE: begin
                if (halt) begin
                    state_d = ST_SCAN;
                end else if ((dmemren || dmemwen) && !hit) begin
                    state_d = victim_dirty ? ST_WB1 : ST_LD1;
                end
            end
            ST_WB1:    if (!dwait) state_d = ST_WB2;
            ST_WB2:    if (!dwait) state_d = ST_LD1;
            ST_LD1:    if (!dwait) state_d = ST_LD2;
            ST_LD2:    if (!dwait) state_d = ST_IDLE;   // retry the lookup
            ST_SCAN: begin
                if (scan_valid_dirty) begin
                    state_d = ST_FLUSH1;
                end else if (scan_q == LAST_FRAME) begin
                    state_d = ST_HALTED;
                end else begin
                    scan_d = scan_q + 1'b1;
                end
            end
            ST_FLUSH1: if (!dwait) state_d = ST_FLUSH2;
            ST_FLUSH2: begin
                if (!dwait) begin
                    if (scan_q == LAST_FRAME) begin
                        state_d = ST_HALTED;
                    end else begin
                        state_d = ST_SCAN;
                        scan_d  = scan_q + 1'b1;
                    end
                end
            end
            ST_HALTED: state_d = ST_HALTED;     // only reset leaves
            default:   state_d = ST_IDLE;
        endcase
    end

    // memory strobes and refill writes straight from the state
    always_comb begin
        dren      = 1'b0;
        dwen      = 1'b0;
        daddr     = dmemaddr;
        dstore    = '0;
        fill_en   = 1'b0;
        fill_blk  = 1'b0;
        fill_last = 1'b0;
        case (state_q)
            ST_WB1: begin
                dwen   = 1'b1;
                daddr  = blk_addr(victim_tag, req_idx, 1'b0);
                dstore = victim_word0;
            end
            ST_WB2: begin
                dwen   = 1'b1;
                daddr  = blk_addr(victim_tag, req_idx, 1'b1);
                dstore = victim_word1;
            end
            ST_LD1: begin
                dren    = 1'b1;
                daddr   = blk_addr(req_tag, req_idx, 1'b0);
                fill_en = !dwait;
            end
            ST_LD2: begin
                dren      = 1'b1;
                daddr     = blk_addr(req_tag, req_idx, 1'b1);
                fill_en   = !dwait;
                fill_blk  = 1'b1;
                fill_last = !dwait;     // valid and tag go in with the last word
            end
            ST_FLUSH1: begin
                dwen   = 1'b1;
                daddr  = blk_addr(scan_tag, scan_idx, 1'b0);
                dstore = scan_word0;
            end
            ST_FLUSH2: begin
                dwen   = 1'b1;
                daddr  = blk_addr(scan_tag, scan_idx, 1'b1);
                dstore = scan_word1;
            end
            default: begin
            end
        endcase
    end

    // one memory access at a time
    assert property (@(posedge CLK) disable iff (!nRST) !(dren && dwen))
        else $error("dren and dwen high together");

    // flushed only once the walk has passed every frame
    assert property (@(posedge CLK) disable iff (!nRST) flushed |-> scan_q == LAST_FRAME)
        else $error("flushed before the walk reached the last frame");

endmodule

// ==== verilog/dcache_frames.sv ====
`timescale 1ns/1ns

module dcache_frames #(
    parameter int IDX_W = dcache_pkg::DEF_IDX_W,
    localparam int TAG_W = dcache_pkg::WORD_W - IDX_W - dcache_pkg::BLK_W - dcache_pkg::BYT_W
) (
    input  logic              CLK,
    input  logic              nRST,
    // lookup from the datapath
    input  logic              lookup_en,
    input  logic              dmemren,
    input  logic              dmemwen,
    input  dcache_pkg::word_t dmemaddr,
    input  dcache_pkg::word_t dmemstore,
    output logic              hit,
    output dcache_pkg::word_t dmemload,
    // victim of the addressed set
    output logic              victim_dirty,
    output logic [TAG_W-1:0]  victim_tag,
    output dcache_pkg::word_t victim_word0,
    output dcache_pkg::word_t victim_word1,
    // refill
    input  logic              fill_en,
    input  logic              fill_blk,
    input  logic              fill_last,
    input  dcache_pkg::word_t dload,
    // flush walk
    input  logic [IDX_W:0]    scan_frame,
    output logic              scan_valid_dirty,
    output logic [TAG_W-1:0]  scan_tag,
    output dcache_pkg::word_t scan_word0,
    output dcache_pkg::word_t scan_word1
);
    import dcache_pkg::*;

    localparam int SETS = 1 << IDX_W;
    localparam int WPB  = 1 << BLK_W;   // words per block

    logic [TAG_W-1:0] tag_q  [2][SETS];
    word_t            data_q [2][SETS][WPB];
    logic [SETS-1:0]  valid_q [2];
    logic [SETS-1:0]  dirty_q [2];
    logic [SETS-1:0]  lru_q;            // way to replace next, per set

    logic [TAG_W-1:0] req_tag;
    logic [IDX_W-1:0] req_idx;
    logic [BLK_W-1:0] req_blk;
    logic [1:0]       way_hit;
    logic             hit_way;
    logic             vic_way;
    logic             scan_way;
    logic [IDX_W-1:0] scan_idx;

    // tag | index | block offset | byte offset
    assign req_tag = dmemaddr[WORD_W-1 -: TAG_W];
    assign req_idx = dmemaddr[BYT_W+BLK_W +: IDX_W];
    assign req_blk = dmemaddr[BYT_W +: BLK_W];

    always_comb begin
        for (int w = 0; w < 2; w++) begin
            way_hit[w] = valid_q[w][req_idx] && (tag_q[w][req_idx] == req_tag);
        end
    end

    assign hit_way  = way_hit[1];
    assign hit      = lookup_en && (dmemren || dmemwen) && (way_hit != 2'b00);
    assign dmemload = data_q[hit_way][req_idx][req_blk];

    // victim is whichever way the recency bit names
    assign vic_way      = lru_q[req_idx];
    assign victim_dirty = valid_q[vic_way][req_idx] && dirty_q[vic_way][req_idx];
    assign victim_tag   = tag_q[vic_way][req_idx];
    assign victim_word0 = data_q[vic_way][req_idx][0];
    assign victim_word1 = data_q[vic_way][req_idx][1];

    // frame number: top bit picks the way, the rest the set
    assign scan_way         = scan_frame[IDX_W];
    assign scan_idx         = scan_frame[IDX_W-1:0];
    assign scan_valid_dirty = valid_q[scan_way][scan_idx] && dirty_q[scan_way][scan_idx];
    assign scan_tag         = tag_q[scan_way][scan_idx];
    assign scan_word0       = data_q[scan_way][scan_idx][0];
    assign scan_word1       = data_q[scan_way][scan_idx][1];

    // frame state and recency
    always_ff @(posedge CLK, negedge nRST) begin
        if (!nRST) begin
            valid_q <= '{default: '0};
            dirty_q <= '{default: '0};
            lru_q   <= '0;
        end else begin
            if (hit) begin
                lru_q[req_idx] <= ~hit_way;   // other way goes next
                if (dmemwen) begin
                    dirty_q[hit_way][req_idx] <= 1'b1;
                end
            end
            if (fill_en && fill_last) begin
                valid_q[vic_way][req_idx] <= 1'b1;
                dirty_q[vic_way][req_idx] <= 1'b0;
            end
        end
    end

    // tags and data
    always_ff @(posedge CLK) begin
        if (hit && dmemwen) begin
            data_q[hit_way][req_idx][req_blk] <= dmemstore;
        end
        if (fill_en) begin
            data_q[vic_way][req_idx][fill_blk] <= dload;
        end
        if (fill_en && fill_last) begin
            tag_q[vic_way][req_idx] <= req_tag;
        end
    end

    // a refill only follows a miss, so a tag never lands in both ways
    assert property (@(posedge CLK) disable iff (!nRST) !(way_hit[0] && way_hit[1]))
        else $error("both ways hit in set %0d", req_idx);

endmodule

// ==== verilog/dcache_pkg.sv ====
package dcache_pkg;

    // word and address field widths
    localparam int WORD_W    = 32;
    localparam int BYT_W     = 2;   // byte offset within a word
    localparam int BLK_W     = 1;   // two words per block
    localparam int DEF_IDX_W = 3;   // eight sets by default

    typedef logic [WORD_W-1:0] word_t;

    // controller states, the normal miss path first
    typedef enum logic [3:0] {
        ST_IDLE,
        ST_WB1,     // victim word 0 out
        ST_WB2,     // victim word 1 out
        ST_LD1,     // refill word 0
        ST_LD2,     // refill word 1
        ST_SCAN,    // walk frames after halt
        ST_FLUSH1,
        ST_FLUSH2,
        ST_HALTED
    } ctrl_state_t;

endpackage
